//--- fft_stage_cfg.svh
`ifndef FFT_STAGE_CFG_SVH
`define FFT_STAGE_CFG_SVH

// sample component width, real and imaginary each
`define FFT_DW 16

// twiddle component width and its fraction bits (Q1.14)
`define FFT_TW_W 16
`define FFT_TW_FRAC 14

// samples per block and store pointer width
`define FFT_DEPTH 16
`define FFT_PTR_W 4

// credits granted by downstream after reset
`define FFT_OUT_CREDITS 4

`endif

//--- fft_pkg.sv
`default_nettype none
`include "fft_stage_cfg.svh"

package fft_pkg;

    // one complex sample
    typedef struct packed {
        logic signed [`FFT_DW-1:0] re;
        logic signed [`FFT_DW-1:0] im;
    } cplx_t;

    // twiddle factor in fixed point
    typedef struct packed {
        logic signed [`FFT_TW_W-1:0] re;
        logic signed [`FFT_TW_W-1:0] im;
    } tw_t;

    // a is sample k, b is sample k+8
    typedef struct packed {
        cplx_t a;
        cplx_t b;
    } cplx_pair_t;

    // output beat of the butterfly
    typedef struct packed {
        cplx_t sum;
        cplx_t diff;
    } bfly_out_t;

endpackage

`default_nettype wire

//--- pair_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_stage_cfg.svh"

module pair_buffer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                in_valid_i,
    input  wire fft_pkg::cplx_t      in_data_i,
    input  wire logic                issue_ok_i,
    output logic                     rd_start_o,
    output logic                     pair_valid_o,
    output fft_pkg::cplx_pair_t      pair_o,
    output logic                     in_credit_o
);

    localparam int unsigned LAST_IDX = `FFT_DEPTH - 1;
    localparam int unsigned PAIR_W = `FFT_PTR_W - 1;

    typedef enum logic {
        RD_FIRST,
        RD_SECOND
    } rd_state_e;

    fft_pkg::cplx_t         mem [`FFT_DEPTH];
    fft_pkg::cplx_t         rd_q;
    fft_pkg::cplx_t         a_q;

    logic [`FFT_PTR_W-1:0]  wr_ptr_q;
    logic                   full_q;
    rd_state_e              rd_state_q;
    logic [PAIR_W-1:0]      pair_idx_q;
    logic [`FFT_PTR_W-1:0]  rd_addr;
    logic                   rd_en;
    logic                   last_pair;
    logic                   ret_active_q;
    logic [`FFT_PTR_W-1:0]  ret_cnt_q;

    // sequential writes, one sample per beat
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            full_q   <= 1'b0;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (last_pair) begin
                full_q <= 1'b0;
            end else if (in_valid_i && (wr_ptr_q == LAST_IDX[`FFT_PTR_W-1:0])) begin
                full_q <= 1'b1;
            end
        end
    end

    // a pair starts only on a full block with a free output credit
    assign rd_start_o = (rd_state_q == RD_FIRST) && full_q && issue_ok_i;
    assign rd_en      = rd_start_o || (rd_state_q == RD_SECOND);
    // first read k, second read k+8
    assign rd_addr    = {rd_state_q == RD_SECOND, pair_idx_q};
    assign last_pair  = (rd_state_q == RD_SECOND) && (pair_idx_q == '1);

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
        // hold A while B is read
        if (rd_state_q == RD_SECOND) begin
            a_q <= rd_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state_q   <= RD_FIRST;
            pair_idx_q   <= '0;
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= (rd_state_q == RD_SECOND);
            case (rd_state_q)
                RD_FIRST: begin
                    if (rd_start_o) begin
                        rd_state_q <= RD_SECOND;
                    end
                end
                RD_SECOND: begin
                    rd_state_q <= RD_FIRST;
                    pair_idx_q <= pair_idx_q + 1'b1;
                end
                default: rd_state_q <= RD_FIRST;
            endcase
        end
    end

    always_comb begin
        pair_o.a = a_q;
        pair_o.b = rd_q;
    end

    // give back the whole block of input credits, one per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_active_q <= 1'b0;
            ret_cnt_q    <= '0;
        end else if (last_pair) begin
            ret_active_q <= 1'b1;
            ret_cnt_q    <= '0;
        end else if (ret_active_q) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
            if (ret_cnt_q == LAST_IDX[`FFT_PTR_W-1:0]) begin
                ret_active_q <= 1'b0;
            end
        end
    end

    assign in_credit_o = ret_active_q;

endmodule

`default_nettype wire

//--- twiddle_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_stage_cfg.svh"

module twiddle_gen (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rd_start_i,
    output fft_pkg::tw_t    tw_o
);

    localparam int unsigned IDX_W = `FFT_PTR_W - 1;
    localparam int unsigned N_TW = `FFT_DEPTH / 2;

    // each word is {re, im}, W_k for k = 0..7
    logic [2*`FFT_TW_W-1:0] rom [N_TW];

    logic [IDX_W-1:0]       cnt_q;
    logic [IDX_W-1:0]       idx_q;
    logic                   lookup_q;
    fft_pkg::tw_t           tw_q;

    initial begin
        $readmemh("twiddle_rom.mem", rom);
    end

    // index wraps by itself after the eighth pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q    <= '0;
            idx_q    <= '0;
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= rd_start_i;
            if (rd_start_i) begin
                idx_q <= cnt_q;
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // table output lands with pair_valid
    always_ff @(posedge clk) begin
        if (lookup_q) begin
            tw_q <= fft_pkg::tw_t'(rom[idx_q]);
        end
    end

    assign tw_o = tw_q;

endmodule

`default_nettype wire

//--- butterfly_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_stage_cfg.svh"

module butterfly_unit (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pair_valid_i,
    input  wire fft_pkg::cplx_pair_t    pair_i,
    input  wire fft_pkg::tw_t           tw_i,
    input  wire logic                   rd_start_i,
    input  wire logic                   out_credit_i,
    output logic                        issue_ok_o,
    output logic                        out_valid_o,
    output fft_pkg::bfly_out_t          out_data_o
);

    localparam int unsigned PW = `FFT_DW + `FFT_TW_W + 1;
    localparam int unsigned CW = $clog2(`FFT_OUT_CREDITS + 1);

    logic signed [PW-1:0]       prod_re;
    logic signed [PW-1:0]       prod_im;
    logic signed [PW-1:0]       prod_re_sh;
    logic signed [PW-1:0]       prod_im_sh;
    fft_pkg::cplx_t             p_d;
    fft_pkg::cplx_t             p_q;
    fft_pkg::cplx_t             a_q;
    logic                       mul_valid_q;
    logic signed [`FFT_DW:0]    sum_re;
    logic signed [`FFT_DW:0]    sum_im;
    logic signed [`FFT_DW:0]    diff_re;
    logic signed [`FFT_DW:0]    diff_im;
    fft_pkg::bfly_out_t         out_d;
    logic [CW-1:0]              credit_q;

    // P = B * W, back to sample scale by truncation
    always_comb begin
        prod_re    = pair_i.b.re * tw_i.re - pair_i.b.im * tw_i.im;
        prod_im    = pair_i.b.re * tw_i.im + pair_i.b.im * tw_i.re;
        prod_re_sh = prod_re >>> `FFT_TW_FRAC;
        prod_im_sh = prod_im >>> `FFT_TW_FRAC;
        p_d.re     = prod_re_sh[`FFT_DW-1:0];
        p_d.im     = prod_im_sh[`FFT_DW-1:0];
    end

    always_ff @(posedge clk) begin
        if (pair_valid_i) begin
            p_q <= p_d;
            a_q <= pair_i.a;
        end
    end

    // one extra bit for the add, then halve
    always_comb begin
        sum_re         = a_q.re + p_q.re;
        sum_im         = a_q.im + p_q.im;
        diff_re        = a_q.re - p_q.re;
        diff_im        = a_q.im - p_q.im;
        out_d.sum.re   = sum_re[`FFT_DW:1];
        out_d.sum.im   = sum_im[`FFT_DW:1];
        out_d.diff.re  = diff_re[`FFT_DW:1];
        out_d.diff.im  = diff_im[`FFT_DW:1];
    end

    always_ff @(posedge clk) begin
        if (mul_valid_q) begin
            out_data_o <= out_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_valid_q <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            mul_valid_q <= pair_valid_i;
            out_valid_o <= mul_valid_q;
        end
    end

    // spent at issue, not at output, so in-flight pairs always have room
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= CW'(`FFT_OUT_CREDITS);
        end else begin
            case ({rd_start_i, out_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    assign issue_ok_o = (credit_q != '0);

endmodule

`default_nettype wire

//--- fft_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid_i,
    input  wire fft_pkg::cplx_t     in_data_i,
    output logic                    in_credit_o,
    output logic                    out_valid_o,
    output fft_pkg::bfly_out_t      out_data_o,
    input  wire logic               out_credit_i
);

    logic                   rd_start;
    logic                   pair_valid;
    logic                   issue_ok;
    fft_pkg::cplx_pair_t    pair;
    fft_pkg::tw_t           tw;

    // sample store and pair sequencer
    pair_buffer u_pair_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .issue_ok_i   (issue_ok),
        .rd_start_o   (rd_start),
        .pair_valid_o (pair_valid),
        .pair_o       (pair),
        .in_credit_o  (in_credit_o)
    );

    // runs beside the buffer, same rd_start
    twiddle_gen u_twiddle_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_start_i (rd_start),
        .tw_o       (tw)
    );

    butterfly_unit u_butterfly_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .pair_valid_i (pair_valid),
        .pair_i       (pair),
        .tw_i         (tw),
        .rd_start_i   (rd_start),
        .out_credit_i (out_credit_i),
        .issue_ok_o   (issue_ok),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o)
    );

endmodule

`default_nettype wire

//--- fft_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_stage_cfg.svh"

module fft_stage_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic rd_start_i,
    input wire logic in_credit_i,
    input wire logic out_valid_i,
    input wire logic out_credit_i
);

    localparam int unsigned CW = $clog2(`FFT_OUT_CREDITS + 1) + 1;

    logic [CW-1:0] avail_q;

    // credits downstream still owes us, counted at the output beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avail_q <= CW'(`FFT_OUT_CREDITS);
        end else begin
            case ({out_valid_i, out_credit_i})
                2'b10:   avail_q <= avail_q - 1'b1;
                2'b01:   avail_q <= avail_q + 1'b1;
                default: avail_q <= avail_q;
            endcase
        end
    end

    a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_i |-> (avail_q != '0))
        else $error("output beat sent with no credit outstanding");

    a_reset_credit: assert property (@(posedge clk) !rst_n |-> !in_credit_i)
        else $error("input credit returned during reset");

    // fixed four cycle latency, both directions
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rd_start_i, 4) |-> out_valid_i)
        else $error("no output beat four cycles after pair start");

    a_lat_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_i |-> $past(rd_start_i, 4))
        else $error("output beat without a pair start four cycles earlier");

endmodule

`default_nettype wire

//--- tb_fft_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_stage_cfg.svh"

module tb_fft_stage;

    localparam int HALF = `FFT_DEPTH / 2;
    localparam int TIMEOUT = 300;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid_i;
    fft_pkg::cplx_t         in_data_i;
    logic                   in_credit_o;
    logic                   out_valid_o;
    fft_pkg::bfly_out_t     out_data_o;
    logic                   out_credit_i;

    logic [2*`FFT_TW_W-1:0] tw_tab [HALF];
    fft_pkg::cplx_t         blk [`FFT_DEPTH];
    fft_pkg::bfly_out_t     exp_beats [HALF];
    fft_pkg::bfly_out_t     got_q [$];
    int                     in_credits;
    int                     in_credit_pulses;
    int                     credit_pending;
    int                     credit_release;
    logic                   give_credit;
    logic                   auto_credit;
    integer                 seed;
    int                     n_checks;
    int                     n_errors;
    int                     test_errors;

    fft_stage_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_credit_i (out_credit_i)
    );

    bind fft_stage_top fft_stage_assert u_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_start_i   (rd_start),
        .in_credit_i  (in_credit_o),
        .out_valid_i  (out_valid_o),
        .out_credit_i (out_credit_i)
    );

    always #2 clk = ~clk;

    // sampled at the rising edge, before the DUT registers move
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid_o) begin
                got_q.push_back(out_data_o);
                if (auto_credit) begin
                    credit_pending++;
                end
            end
            if (in_credit_o) begin
                in_credits++;
                in_credit_pulses++;
            end
            credit_pending += credit_release;
            credit_release = 0;
            give_credit = (credit_pending != 0);
            if (give_credit) begin
                credit_pending--;
            end
        end
    end

    always @(negedge clk) begin
        out_credit_i <= give_credit;
    end

    task automatic note_error(input string msg);
        $display("%s", msg);
        n_errors++;
        test_errors++;
    endtask

    task automatic check_val(input string what, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            note_error($sformatf("CHECK FAILED @%0t: %s got %0d expected %0d",
                $time, what, got, exp));
        end
    endtask

    function automatic logic [`FFT_DW-1:0] halve(input int v);
        int s;
        s = v >>> 1;
        return s[`FFT_DW-1:0];
    endfunction

    // P = B*W back at sample scale, then (A +/- P)/2 with one extra bit
    function automatic fft_pkg::bfly_out_t model_beat(input fft_pkg::cplx_t a,
        input fft_pkg::cplx_t b, input logic [2*`FFT_TW_W-1:0] w);
        longint wr;
        longint wi;
        longint pr;
        longint pi;
        fft_pkg::cplx_t p;
        fft_pkg::bfly_out_t r;
        wr = longint'($signed(w[2*`FFT_TW_W-1:`FFT_TW_W]));
        wi = longint'($signed(w[`FFT_TW_W-1:0]));
        pr = (longint'(b.re) * wr - longint'(b.im) * wi) >>> `FFT_TW_FRAC;
        pi = (longint'(b.re) * wi + longint'(b.im) * wr) >>> `FFT_TW_FRAC;
        p.re = pr[`FFT_DW-1:0];
        p.im = pi[`FFT_DW-1:0];
        r.sum.re = halve(int'(a.re) + int'(p.re));
        r.sum.im = halve(int'(a.im) + int'(p.im));
        r.diff.re = halve(int'(a.re) - int'(p.re));
        r.diff.im = halve(int'(a.im) - int'(p.im));
        return r;
    endfunction

    task automatic random_block();
        logic [31:0] rnd;
        for (int i = 0; i < `FFT_DEPTH; i++) begin
            rnd = $random(seed);
            blk[i].re = rnd[15:0];
            blk[i].im = rnd[31:16];
        end
        for (int k = 0; k < HALF; k++) begin
            exp_beats[k] = model_beat(blk[k], blk[k + HALF], tw_tab[k]);
        end
    endtask

    // one sample per cycle while input credits last
    task automatic send_block();
        int waited;
        for (int i = 0; i < `FFT_DEPTH; i++) begin
            waited = 0;
            while (in_credits == 0 && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (in_credits == 0) begin
                note_error($sformatf("timed out with no input credit for sample %0d", i));
            end else begin
                in_valid_i = 1'b1;
                in_data_i = blk[i];
                in_credits--;
            end
            @(negedge clk);
            in_valid_i = 1'b0;
        end
    endtask

    task automatic wait_beats(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (got_q.size() < n) begin
            note_error($sformatf("timed out with %0d of %0d output beats", got_q.size(), n));
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((in_credits != `FFT_DEPTH || credit_pending != 0 || out_credit_i)
               && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (in_credits != `FFT_DEPTH) begin
            note_error("timed out waiting for the input credits to come back");
        end
    endtask

    // reset lands while the block's input credits are still coming back
    task automatic reset_during_return();
        int waited;
        waited = 0;
        while (!in_credit_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_credit_o) begin
            note_error("timed out waiting for input credits to start coming back");
        end
        rst_n = 1'b0;
        give_credit = 1'b0;
        credit_pending = 0;
        repeat (8) @(negedge clk);
        check_val("in_credit_o during reset", int'(in_credit_o), 0);
        rst_n = 1'b1;
        in_credits = `FFT_DEPTH;
    endtask

    task automatic check_block();
        fft_pkg::bfly_out_t got;
        for (int k = 0; k < HALF; k++) begin
            if (got_q.size() == 0) begin
                note_error($sformatf("output beat %0d never arrived", k));
            end else begin
                got = got_q.pop_front();
                check_val($sformatf("beat %0d sum.re", k), int'(got.sum.re),
                    int'(exp_beats[k].sum.re));
                check_val($sformatf("beat %0d sum.im", k), int'(got.sum.im),
                    int'(exp_beats[k].sum.im));
                check_val($sformatf("beat %0d diff.re", k), int'(got.diff.re),
                    int'(exp_beats[k].diff.re));
                check_val($sformatf("beat %0d diff.im", k), int'(got.diff.im),
                    int'(exp_beats[k].diff.im));
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_val("in_credit_o while idle", int'(in_credit_o), 0);
            check_val("out_valid_o while idle", int'(out_valid_o), 0);
        end
        check_val("beats seen while idle", got_q.size(), 0);
        end_test("reset_idle");
    endtask

    task automatic test_impulse();
        for (int i = 0; i < `FFT_DEPTH; i++) begin
            blk[i] = '0;
        end
        blk[0].re = 16'sd1000;
        for (int k = 0; k < HALF; k++) begin
            exp_beats[k] = '0;
        end
        exp_beats[0].sum.re = 16'sd500;
        exp_beats[0].diff.re = 16'sd500;
        send_block();
        wait_beats(HALF);
        check_block();
        wait_idle();
        end_test("impulse");
    endtask

    task automatic test_random();
        random_block();
        send_block();
        wait_beats(HALF);
        check_block();
        wait_idle();
        end_test("random");
    endtask

    task automatic test_backpressure();
        auto_credit = 1'b0;
        random_block();
        send_block();
        wait_beats(`FFT_OUT_CREDITS);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
        end
        check_val("beats with credits held back", got_q.size(), `FFT_OUT_CREDITS);
        credit_release = `FFT_OUT_CREDITS;
        auto_credit = 1'b1;
        wait_beats(HALF);
        check_block();
        wait_idle();
        end_test("backpressure");
    endtask

    task automatic test_credit_return();
        int start;
        start = in_credit_pulses;
        random_block();
        send_block();
        wait_beats(HALF);
        check_block();
        wait_idle();
        // quiet window to catch any extra credit pulse
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
        end
        check_val("input credit pulses per block", in_credit_pulses - start, `FFT_DEPTH);
        random_block();
        send_block();
        wait_beats(HALF);
        check_block();
        reset_during_return();
        end_test("credit_return");
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid_i = 1'b0;
        in_data_i = '0;
        out_credit_i <= 1'b0;
        give_credit = 1'b0;
        auto_credit = 1'b1;
        in_credits = `FFT_DEPTH;
        in_credit_pulses = 0;
        credit_pending = 0;
        credit_release = 0;
        seed = 32'h9cdb;
        n_checks = 0;
        n_errors = 0;
        test_errors = 0;
        $readmemh("twiddle_rom.mem", tw_tab);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_idle();
        test_impulse();
        test_random();
        test_backpressure();
        test_credit_return();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- twiddle_rom.mem
// one word per twiddle W_k, k = 0 to 7: upper 16 bits re, lower 16 bits im, Q1.14
40000000
3B21E782
2D41D2BF
187EC4DF
0000C000
E782C4DF
D2BFD2BF
C4DFE782

//--- tb.f
+incdir+.
fft_pkg.sv
pair_buffer.sv
twiddle_gen.sv
butterfly_unit.sv
fft_stage_top.sv
fft_stage_assert.sv
tb_fft_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FFT stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_fft_stage -o sim_fft_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fft_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
